/* files.f */
rtl/arm_isa_pkg.sv
rtl/core_bus_pkg.sv
rtl/load_align.sv
rtl/fetch_unit.sv
rtl/instr_queue.sv
rtl/exec_core.sv
rtl/mini_arm_top.sv
verification/mini_arm_assertions.sv
verification/mini_arm_tb.sv

/* rtl/arm_isa_pkg.sv */
package arm_isa_pkg;

  // ==================================================
  // Instruction word fields
  // ==================================================
  localparam int OPC_LSB     = 28;
  localparam int OPC_W       = 4;
  localparam int RD_LSB      = 24;  // Destination, or store source
  localparam int RN_LSB      = 20;  // First operand or base address
  localparam int RM_LSB      = 16;
  localparam int USE_IMM_BIT = 15;  // Immediate replaces Rm on the B bus
  localparam int SIZE_LSB    = 12;
  localparam int SIZE_W      = 2;
  localparam int SIGNED_BIT  = 11;  // Loads only
  localparam int IMM_LSB     = 0;
  localparam int IMM_W       = 11;  // Zero-extended

  // Register file
  localparam int NUM_REGS       = 16;
  localparam int REG_IDX_W      = $clog2(NUM_REGS);
  localparam int PC_REG         = 15;
  localparam int PC_READ_OFFSET = 4;  // R15 reads as own address + 4

  typedef enum logic [OPC_W-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_ORR  = 4'd3,
    OP_EOR  = 4'd4,
    OP_MOV  = 4'd5,  // Result is the B bus
    OP_LDR  = 4'd6,
    OP_STR  = 4'd7,
    OP_HALT = 4'd8
  } opcode_t;

  typedef enum logic [SIZE_W-1:0] {
    XFER_WORD = 2'd0,
    XFER_HALF = 2'd1,
    XFER_BYTE = 2'd2
  } xfer_size_t;

  // Execute core sequencing
  typedef enum logic [1:0] {
    ST_RUN  = 2'd0,  // Accepting from the queue
    ST_MEM  = 2'd1,  // Data access outstanding
    ST_HALT = 2'd2
  } exec_state_t;

endpackage

/* rtl/core_bus_pkg.sv */
package core_bus_pkg;

  // ==================================================
  // Memory side widths and constants
  // ==================================================
  localparam int WORD_W = 32;  // Addresses and data alike

  // Sequential fetch step
  localparam logic [WORD_W-1:0] INSTR_BYTES = 32'd4;

  // Fetch restarts here after reset
  localparam logic [WORD_W-1:0] RESET_PC = 32'h0000_0000;

  // Instruction queue between fetch and execute
  localparam int QUEUE_DEPTH = 4;  // Power of two, pointers wrap
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

endpackage

/* rtl/exec_core.sv */
`timescale 1ns/10ps

module exec_core (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            q_valid,
  output logic                            q_ready,
  input  logic [core_bus_pkg::WORD_W-1:0] q_pc,
  input  logic [core_bus_pkg::WORD_W-1:0] q_instr,
  output logic                            dmem_valid,
  output logic                            dmem_write,
  output arm_isa_pkg::xfer_size_t         dmem_size,
  output logic [core_bus_pkg::WORD_W-1:0] dmem_addr,
  output logic [core_bus_pkg::WORD_W-1:0] dmem_wdata,
  input  logic                            dmem_ready,
  input  logic [core_bus_pkg::WORD_W-1:0] dmem_rdata,
  output logic                            flush,
  output logic [core_bus_pkg::WORD_W-1:0] flush_pc,
  output logic                            halted
);

  arm_isa_pkg::exec_state_t        state;
  logic [core_bus_pkg::WORD_W-1:0] regs [arm_isa_pkg::NUM_REGS];
  logic [core_bus_pkg::WORD_W-1:0] instr_q;  // Transfer held during ST_MEM
  logic [core_bus_pkg::WORD_W-1:0] pc_q;
  logic [core_bus_pkg::WORD_W-1:0] addr_q;

  logic [core_bus_pkg::WORD_W-1:0]    cur_instr;
  logic [core_bus_pkg::WORD_W-1:0]    cur_pc;
  arm_isa_pkg::opcode_t               opcode;
  logic [arm_isa_pkg::REG_IDX_W-1:0]  rd;
  logic [arm_isa_pkg::REG_IDX_W-1:0]  rn;
  logic [arm_isa_pkg::REG_IDX_W-1:0]  rm;
  logic                               use_imm;
  arm_isa_pkg::xfer_size_t            size;
  logic                               signed_load;
  logic [core_bus_pkg::WORD_W-1:0]    imm_ext;
  logic [core_bus_pkg::WORD_W-1:0]    a_bus;
  logic [core_bus_pkg::WORD_W-1:0]    b_bus;
  logic [core_bus_pkg::WORD_W-1:0]    rd_val;
  logic [core_bus_pkg::WORD_W-1:0]    alu_result;
  logic [core_bus_pkg::WORD_W-1:0]    load_data;
  logic                               is_alu;
  logic                               is_xfer;
  logic                               accept;
  logic                               mem_done;
  logic                               wb_en;
  logic [core_bus_pkg::WORD_W-1:0]    wb_data;

  function automatic logic [core_bus_pkg::WORD_W-1:0] read_reg(
    input logic [arm_isa_pkg::REG_IDX_W-1:0] idx,
    input logic [core_bus_pkg::WORD_W-1:0]   pc
  );
    if (idx == arm_isa_pkg::PC_REG) begin
      return pc + arm_isa_pkg::PC_READ_OFFSET;
    end
    return regs[idx];
  endfunction

  // ==================================================
  // Decode
  // ==================================================
  assign cur_instr = (state == arm_isa_pkg::ST_MEM) ? instr_q : q_instr;
  assign cur_pc    = (state == arm_isa_pkg::ST_MEM) ? pc_q : q_pc;

  assign opcode = arm_isa_pkg::opcode_t'(cur_instr[arm_isa_pkg::OPC_LSB +: arm_isa_pkg::OPC_W]);
  assign rd     = cur_instr[arm_isa_pkg::RD_LSB +: arm_isa_pkg::REG_IDX_W];
  assign rn     = cur_instr[arm_isa_pkg::RN_LSB +: arm_isa_pkg::REG_IDX_W];
  assign rm     = cur_instr[arm_isa_pkg::RM_LSB +: arm_isa_pkg::REG_IDX_W];
  assign size   = arm_isa_pkg::xfer_size_t'(cur_instr[arm_isa_pkg::SIZE_LSB +: arm_isa_pkg::SIZE_W]);
  assign use_imm     = cur_instr[arm_isa_pkg::USE_IMM_BIT];
  assign signed_load = cur_instr[arm_isa_pkg::SIGNED_BIT];
  assign imm_ext = {{(core_bus_pkg::WORD_W-arm_isa_pkg::IMM_W){1'b0}},
                    cur_instr[arm_isa_pkg::IMM_LSB +: arm_isa_pkg::IMM_W]};

  assign is_alu  = (opcode inside {arm_isa_pkg::OP_ADD, arm_isa_pkg::OP_SUB, arm_isa_pkg::OP_AND,
                                   arm_isa_pkg::OP_ORR, arm_isa_pkg::OP_EOR, arm_isa_pkg::OP_MOV});
  assign is_xfer = (opcode == arm_isa_pkg::OP_LDR) || (opcode == arm_isa_pkg::OP_STR);

  // Operand buses
  assign a_bus  = read_reg(rn, cur_pc);
  assign b_bus  = use_imm ? imm_ext : read_reg(rm, cur_pc);
  assign rd_val = read_reg(rd, cur_pc);  // Store source

  always_comb begin
    case (opcode)
      arm_isa_pkg::OP_SUB: alu_result = a_bus - b_bus;
      arm_isa_pkg::OP_AND: alu_result = a_bus & b_bus;
      arm_isa_pkg::OP_ORR: alu_result = a_bus | b_bus;
      arm_isa_pkg::OP_EOR: alu_result = a_bus ^ b_bus;
      arm_isa_pkg::OP_MOV: alu_result = b_bus;
      default:             alu_result = a_bus + b_bus;  // ADD and transfer address
    endcase
  end

  // ==================================================
  // Data memory side
  // ==================================================
  assign dmem_valid = (state == arm_isa_pkg::ST_MEM);
  assign dmem_write = dmem_valid & (opcode == arm_isa_pkg::OP_STR);
  assign dmem_size  = size;
  assign dmem_addr  = addr_q;
  assign mem_done   = dmem_valid & dmem_ready;

  always_comb begin
    case (size)
      arm_isa_pkg::XFER_BYTE: dmem_wdata = {{(core_bus_pkg::WORD_W-8){1'b0}}, rd_val[7:0]};
      arm_isa_pkg::XFER_HALF: dmem_wdata = {{(core_bus_pkg::WORD_W-16){1'b0}}, rd_val[15:0]};
      default:                dmem_wdata = rd_val;
    endcase
  end

  load_align u_load_align (
    .rdata      (dmem_rdata),
    .addr_low   (addr_q[1:0]),
    .size       (size),
    .signed_load(signed_load),
    .result     (load_data)
  );

  // Writeback, a write to R15 redirects fetch
  assign q_ready  = (state == arm_isa_pkg::ST_RUN);
  assign accept   = q_valid & q_ready;
  assign wb_en    = (accept & is_alu) | (mem_done & (opcode == arm_isa_pkg::OP_LDR));
  assign wb_data  = dmem_valid ? load_data : alu_result;
  assign flush    = wb_en & (rd == arm_isa_pkg::PC_REG);
  assign flush_pc = wb_data;
  assign halted   = (state == arm_isa_pkg::ST_HALT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= arm_isa_pkg::ST_RUN;
    end else begin
      case (state)
        arm_isa_pkg::ST_RUN: begin
          if (accept && is_xfer) begin
            state <= arm_isa_pkg::ST_MEM;
          end else if (accept && opcode == arm_isa_pkg::OP_HALT) begin
            state <= arm_isa_pkg::ST_HALT;
          end
        end
        arm_isa_pkg::ST_MEM:  if (mem_done) state <= arm_isa_pkg::ST_RUN;
        arm_isa_pkg::ST_HALT: state <= arm_isa_pkg::ST_HALT;  // Only reset leaves
        default:              state <= arm_isa_pkg::ST_RUN;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      instr_q <= q_instr;
      pc_q    <= q_pc;
      addr_q  <= alu_result;
    end
    if (wb_en) begin
      regs[rd] <= wb_data;
    end
  end

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
  input  logic                            clk,
  input  logic                            reset,
  output logic                            imem_req,
  output logic [core_bus_pkg::WORD_W-1:0] imem_addr,
  input  logic [core_bus_pkg::WORD_W-1:0] imem_rdata,
  output logic                            fetch_valid,
  input  logic                            fetch_ready,
  output logic [core_bus_pkg::WORD_W-1:0] fetch_pc,
  output logic [core_bus_pkg::WORD_W-1:0] fetch_instr,
  input  logic                            flush,
  input  logic [core_bus_pkg::WORD_W-1:0] flush_pc
);

  logic                            running;     // Set one cycle after reset
  logic [core_bus_pkg::WORD_W-1:0] next_pc;
  logic [core_bus_pkg::WORD_W-1:0] req_pc;      // Address of the request in flight
  logic                            resp_valid;  // imem_rdata holds a live word
  logic                            hold_valid;
  logic [core_bus_pkg::WORD_W-1:0] hold_pc;
  logic [core_bus_pkg::WORD_W-1:0] hold_instr;
  logic                            out_stall;

  // Held word wins; otherwise the word straight off the ROM
  assign fetch_valid = resp_valid | hold_valid;
  assign fetch_pc    = hold_valid ? hold_pc : req_pc;
  assign fetch_instr = hold_valid ? hold_instr : imem_rdata;

  assign out_stall = fetch_valid & ~fetch_ready;
  assign imem_req  = running & ~out_stall;  // Output free or leaving this cycle
  assign imem_addr = next_pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      running    <= 1'b0;
      next_pc    <= core_bus_pkg::RESET_PC;
      resp_valid <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      running    <= 1'b1;
      resp_valid <= imem_req & ~flush;  // Squash anything issued with the old path
      hold_valid <= out_stall & ~flush;

      if (flush) begin
        next_pc <= flush_pc;
      end else if (imem_req) begin
        next_pc <= next_pc + core_bus_pkg::INSTR_BYTES;
      end
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (imem_req) begin
      req_pc <= next_pc;
    end
    if (resp_valid && !hold_valid) begin
      hold_pc    <= req_pc;
      hold_instr <= imem_rdata;
    end
  end

endmodule

/* rtl/instr_queue.sv */
`timescale 1ns/10ps

module instr_queue (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            flush,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [core_bus_pkg::WORD_W-1:0] in_pc,
  input  logic [core_bus_pkg::WORD_W-1:0] in_instr,
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [core_bus_pkg::WORD_W-1:0] out_pc,
  output logic [core_bus_pkg::WORD_W-1:0] out_instr
);

  logic [core_bus_pkg::WORD_W-1:0] pc_mem    [core_bus_pkg::QUEUE_DEPTH];
  logic [core_bus_pkg::WORD_W-1:0] instr_mem [core_bus_pkg::QUEUE_DEPTH];

  logic [core_bus_pkg::QPTR_W-1:0] wr_ptr;
  logic [core_bus_pkg::QPTR_W-1:0] rd_ptr;
  logic [core_bus_pkg::QPTR_W:0]   count;
  logic                            full;
  logic                            push;
  logic                            pop;

  assign full      = (count == core_bus_pkg::QUEUE_DEPTH);
  assign in_ready  = ~full;
  assign out_valid = (count != '0);
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  assign out_pc    = pc_mem[rd_ptr];
  assign out_instr = instr_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset || flush) begin  // Flush drops every entry, including a push this cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pc_mem[wr_ptr]    <= in_pc;
      instr_mem[wr_ptr] <= in_instr;
    end
  end

endmodule

/* rtl/load_align.sv */
`timescale 1ns/10ps

module load_align (
  input  logic [core_bus_pkg::WORD_W-1:0] rdata,     // Aligned word holding the address
  input  logic [1:0]                      addr_low,
  input  arm_isa_pkg::xfer_size_t         size,
  input  logic                            signed_load,
  output logic [core_bus_pkg::WORD_W-1:0] result
);

  logic [2*core_bus_pkg::WORD_W-1:0] doubled;
  logic [core_bus_pkg::WORD_W-1:0]   rotated;

  // Rotate right by 8 * addr_low, addressed byte lands in bits 7:0
  assign doubled = {rdata, rdata} >> {addr_low, 3'b000};
  assign rotated = doubled[core_bus_pkg::WORD_W-1:0];

  always_comb begin
    case (size)
      arm_isa_pkg::XFER_BYTE: begin
        if (signed_load) begin
          result = {{(core_bus_pkg::WORD_W-8){rotated[7]}}, rotated[7:0]};
        end else begin
          result = {{(core_bus_pkg::WORD_W-8){1'b0}}, rotated[7:0]};
        end
      end

      arm_isa_pkg::XFER_HALF: begin
        if (!addr_low[0]) begin  // Even, lane picked by addr_low[1]
          if (signed_load) begin
            result = {{(core_bus_pkg::WORD_W-16){rotated[15]}}, rotated[15:0]};
          end else begin
            result = {{(core_bus_pkg::WORD_W-16){1'b0}}, rotated[15:0]};
          end
        end else if (signed_load) begin
          // ARM7TDMI odd LDRSH behaves as LDRSB
          result = {{(core_bus_pkg::WORD_W-8){rotated[7]}}, rotated[7:0]};
        end else begin
          result = {{(core_bus_pkg::WORD_W-16){1'b0}}, rotated[15:0]};
        end
      end

      default: result = rotated;  // Word, misaligned rotate quirk
    endcase
  end

endmodule

/* rtl/mini_arm_top.sv */
`timescale 1ns/10ps

module mini_arm_top (
  input  logic                            clk,
  input  logic                            reset,
  output logic                            imem_req,
  output logic [core_bus_pkg::WORD_W-1:0] imem_addr,
  input  logic [core_bus_pkg::WORD_W-1:0] imem_rdata,
  output logic                            dmem_valid,
  input  logic                            dmem_ready,
  output logic                            dmem_write,
  output arm_isa_pkg::xfer_size_t         dmem_size,
  output logic [core_bus_pkg::WORD_W-1:0] dmem_addr,
  output logic [core_bus_pkg::WORD_W-1:0] dmem_wdata,
  input  logic [core_bus_pkg::WORD_W-1:0] dmem_rdata,
  output logic                            halted
);

  // Fetch to queue
  logic                            fetch_valid;
  logic                            fetch_ready;
  logic [core_bus_pkg::WORD_W-1:0] fetch_pc;
  logic [core_bus_pkg::WORD_W-1:0] fetch_instr;

  // Queue to execute
  logic                            q_valid;
  logic                            q_ready;
  logic [core_bus_pkg::WORD_W-1:0] q_pc;
  logic [core_bus_pkg::WORD_W-1:0] q_instr;

  // Branch redirect from execute
  logic                            flush;
  logic [core_bus_pkg::WORD_W-1:0] flush_pc;

  fetch_unit u_fetch (
    .clk        (clk),
    .reset      (reset),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .fetch_valid(fetch_valid),
    .fetch_ready(fetch_ready),
    .fetch_pc   (fetch_pc),
    .fetch_instr(fetch_instr),
    .flush      (flush),
    .flush_pc   (flush_pc)
  );

  instr_queue u_queue (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .in_valid (fetch_valid),
    .in_ready (fetch_ready),
    .in_pc    (fetch_pc),
    .in_instr (fetch_instr),
    .out_valid(q_valid),
    .out_ready(q_ready),
    .out_pc   (q_pc),
    .out_instr(q_instr)
  );

  exec_core u_exec (
    .clk       (clk),
    .reset     (reset),
    .q_valid   (q_valid),
    .q_ready   (q_ready),
    .q_pc      (q_pc),
    .q_instr   (q_instr),
    .dmem_valid(dmem_valid),
    .dmem_write(dmem_write),
    .dmem_size (dmem_size),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_ready(dmem_ready),
    .dmem_rdata(dmem_rdata),
    .flush     (flush),
    .flush_pc  (flush_pc),
    .halted    (halted)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the mini ARM testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mini_arm_tb -f files.f \
  -Mdir build/obj_dir -o mini_arm_sim \
  > build/compile.log 2>&1 \
  || { cat build/compile.log; echo "Compile failed"; exit 1; }

./build/obj_dir/mini_arm_sim > build/sim.log 2>&1
sim_status=$?
cat build/sim.log

grep -q "TEST FAIL" build/sim.log && { echo "Simulation reported failure"; exit 1; }
[ "$sim_status" -eq 0 ] && grep -q "TEST PASS" build/sim.log \
  || { echo "Simulation ended without a pass verdict"; exit 1; }
echo "Simulation passed"

/* verification/mini_arm_assertions.sv */
`timescale 1ns/10ps

module mini_arm_assertions (
  input logic                            clk,
  input logic                            reset,
  input logic                            dmem_valid,
  input logic                            dmem_ready,
  input logic [core_bus_pkg::WORD_W-1:0] dmem_addr,
  input logic                            flush,
  input logic                            halted,
  input arm_isa_pkg::exec_state_t        state,
  input logic                            in_valid,
  input logic                            in_ready,
  input logic [core_bus_pkg::WORD_W-1:0] in_pc,
  input logic [core_bus_pkg::WORD_W-1:0] in_instr
);

  // Request held with a stable address until the memory takes it
  dmem_hold: assert property (@(posedge clk) disable iff (reset)
    dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_addr))
    else $error("dmem request dropped or its address moved before ready");

  flush_pulse: assert property (@(posedge clk) disable iff (reset)
    flush |=> !flush)
    else $error("flush held for more than one cycle");

  // Upstream word waits unchanged while the queue is full
  full_stall_hold: assert property (@(posedge clk) disable iff (reset)
    in_valid && !in_ready && !flush |=> in_valid && $stable(in_pc) && $stable(in_instr))
    else $error("fetch word dropped or changed while the queue was full");

  halt_sticky: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted && state == arm_isa_pkg::ST_HALT)
    else $error("core left the halt state");

endmodule

// Queue-side inputs tied off in the core and the other way round
bind exec_core mini_arm_assertions u_exec_checks (
  .clk(clk), .reset(reset),
  .dmem_valid(dmem_valid), .dmem_ready(dmem_ready), .dmem_addr(dmem_addr),
  .flush(flush), .halted(halted), .state(state),
  .in_valid(1'b0), .in_ready(1'b0), .in_pc('0), .in_instr('0)
);

bind instr_queue mini_arm_assertions u_queue_checks (
  .clk(clk), .reset(reset),
  .dmem_valid(1'b0), .dmem_ready(1'b0), .dmem_addr('0),
  .flush(flush), .halted(1'b0), .state(arm_isa_pkg::ST_RUN),
  .in_valid(in_valid), .in_ready(in_ready), .in_pc(in_pc), .in_instr(in_instr)
);

/* verification/mini_arm_tb.sv */
`timescale 1ns/10ps

module mini_arm_tb;

  localparam int CLK_HALF      = 20;
  localparam int RESET_CYCLES  = 10;
  localparam int IMEM_WORDS    = 64;
  localparam int DMEM_BYTES    = 512;
  localparam int STORE_TIMEOUT = 400;  // Cycles allowed per store
  localparam int HALT_TIMEOUT  = 400;
  localparam int QUIET_CYCLES  = 20;   // Watch window after halt
  localparam logic [31:0] POISON = 32'h0000_0666;

  typedef struct packed {
    logic [31:0]             addr;
    arm_isa_pkg::xfer_size_t size;
    logic [31:0]             data;
  } store_t;

  logic                    clk;
  logic                    reset;
  logic                    imem_req;
  logic [31:0]             imem_addr;
  logic [31:0]             imem_rdata;
  logic                    dmem_valid;
  logic                    dmem_ready;
  logic                    dmem_write;
  arm_isa_pkg::xfer_size_t dmem_size;
  logic [31:0]             dmem_addr;
  logic [31:0]             dmem_wdata;
  logic [31:0]             dmem_rdata;
  logic                    halted;

  logic [31:0] imem [IMEM_WORDS];
  logic [7:0]  dmem [DMEM_BYTES];  // Byte lanes, little endian
  logic [31:0] prog_q [$];
  store_t      exp_q [$];
  store_t      got_q [$];
  store_t      seen;
  integer      seed;
  int          mismatch_count;
  int          error_count;
  logic        halt_seen;

  mini_arm_top DUT (
    .clk       (clk),
    .reset     (reset),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_rdata(imem_rdata),
    .dmem_valid(dmem_valid),
    .dmem_ready(dmem_ready),
    .dmem_write(dmem_write),
    .dmem_size (dmem_size),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // ==================================================
  // Instruction encoders
  // ==================================================
  function automatic logic [31:0] imm_instr(input arm_isa_pkg::opcode_t op,
                                            input int rd, input int rn, input int imm);
    return {op, 4'(rd), 4'(rn), 4'd0, 1'b1, 1'b0, 2'b00, 1'b0, 11'(imm)};
  endfunction

  function automatic logic [31:0] reg_instr(input arm_isa_pkg::opcode_t op,
                                            input int rd, input int rn, input int rm);
    return {op, 4'(rd), 4'(rn), 4'(rm), 1'b0, 1'b0, 2'b00, 1'b0, 11'd0};
  endfunction

  function automatic logic [31:0] xfer_instr(input arm_isa_pkg::opcode_t op, input int rd,
                                             input int rn, input arm_isa_pkg::xfer_size_t size,
                                             input logic sgn, input int imm);
    return {op, 4'(rd), 4'(rn), 4'd0, 1'b1, 1'b0, size, sgn, 11'(imm)};
  endfunction

  task automatic add_instr(input logic [31:0] instr);
    prog_q.push_back(instr);
  endtask

  task automatic expect_store(input logic [31:0] addr, input arm_isa_pkg::xfer_size_t size,
                              input logic [31:0] data);
    store_t row;
    row.addr = addr;
    row.size = size;
    row.data = data;
    exp_q.push_back(row);
  endtask

  // ==================================================
  // Program and expected stores
  // ==================================================
  task automatic build_program();
    int r;
    add_instr(imm_instr(arm_isa_pkg::OP_MOV, 1, 0, 'h123));
    add_instr(imm_instr(arm_isa_pkg::OP_MOV, 2, 0, 'h0F0));
    add_instr(reg_instr(arm_isa_pkg::OP_ADD, 3, 1, 2));      // 0x213
    add_instr(imm_instr(arm_isa_pkg::OP_SUB, 4, 3, 'h013));  // 0x200
    add_instr(reg_instr(arm_isa_pkg::OP_AND, 5, 1, 2));      // 0x020
    add_instr(imm_instr(arm_isa_pkg::OP_ORR, 6, 1, 'h400));  // 0x523
    add_instr(reg_instr(arm_isa_pkg::OP_EOR, 7, 6, 2));      // 0x5D3
    add_instr(reg_instr(arm_isa_pkg::OP_SUB, 8, 2, 1));      // Negative result
    add_instr(imm_instr(arm_isa_pkg::OP_MOV, 14, 0, 'h100)); // Store base
    for (r = 3; r <= 8; r++) begin
      add_instr(xfer_instr(arm_isa_pkg::OP_STR, r, 14, arm_isa_pkg::XFER_WORD, 1'b0, (r - 3) * 4));
    end
    expect_store(32'h100, arm_isa_pkg::XFER_WORD, 32'h0000_0213);
    expect_store(32'h104, arm_isa_pkg::XFER_WORD, 32'h0000_0200);
    expect_store(32'h108, arm_isa_pkg::XFER_WORD, 32'h0000_0020);
    expect_store(32'h10C, arm_isa_pkg::XFER_WORD, 32'h0000_0523);
    expect_store(32'h110, arm_isa_pkg::XFER_WORD, 32'h0000_05D3);
    expect_store(32'h114, arm_isa_pkg::XFER_WORD, 32'hFFFF_FFCD);

    // Narrow stores, then read the lanes back as one word
    add_instr(xfer_instr(arm_isa_pkg::OP_STR, 8, 14, arm_isa_pkg::XFER_BYTE, 1'b0, 'h18));
    add_instr(xfer_instr(arm_isa_pkg::OP_STR, 8, 14, arm_isa_pkg::XFER_HALF, 1'b0, 'h1A));
    add_instr(xfer_instr(arm_isa_pkg::OP_STR, 7, 14, arm_isa_pkg::XFER_BYTE, 1'b0, 'h19));
    add_instr(xfer_instr(arm_isa_pkg::OP_LDR, 9, 14, arm_isa_pkg::XFER_WORD, 1'b0, 'h18));
    add_instr(xfer_instr(arm_isa_pkg::OP_STR, 9, 14, arm_isa_pkg::XFER_WORD, 1'b0, 'h1C));
    expect_store(32'h118, arm_isa_pkg::XFER_BYTE, 32'h0000_00CD);
    expect_store(32'h11A, arm_isa_pkg::XFER_HALF, 32'h0000_FFCD);
    expect_store(32'h119, arm_isa_pkg::XFER_BYTE, 32'h0000_00D3);
    expect_store(32'h11C, arm_isa_pkg::XFER_WORD, 32'hFFCD_D3CD);

    // Load formatting against the preloaded words at 0x80
    add_instr(imm_instr(arm_isa_pkg::OP_MOV, 13, 0, 'h80));
    add_instr(xfer_instr(arm_isa_pkg::OP_LDR, 1, 13, arm_isa_pkg::XFER_BYTE, 1'b0, 1));
    add_instr(xfer_instr(arm_isa_pkg::OP_LDR, 2, 13, arm_isa_pkg::XFER_BYTE, 1'b1, 1));
    add_instr(xfer_instr(arm_isa_pkg::OP_LDR, 3, 13, arm_isa_pkg::XFER_HALF, 1'b0, 2));
    add_instr(xfer_instr(arm_isa_pkg::OP_LDR, 4, 13, arm_isa_pkg::XFER_HALF, 1'b1, 2));
    add_instr(xfer_instr(arm_isa_pkg::OP_LDR, 5, 13, arm_isa_pkg::XFER_HALF, 1'b0, 1));  // Odd
    add_instr(xfer_instr(arm_isa_pkg::OP_LDR, 6, 13, arm_isa_pkg::XFER_HALF, 1'b1, 3));  // Odd
    add_instr(xfer_instr(arm_isa_pkg::OP_LDR, 7, 13, arm_isa_pkg::XFER_WORD, 1'b0, 5));
    for (r = 1; r <= 7; r++) begin
      add_instr(xfer_instr(arm_isa_pkg::OP_STR, r, 14, arm_isa_pkg::XFER_WORD, 1'b0,
                           'h20 + (r - 1) * 4));
    end
    expect_store(32'h120, arm_isa_pkg::XFER_WORD, 32'h0000_00C3);
    expect_store(32'h124, arm_isa_pkg::XFER_WORD, 32'hFFFF_FFC3);
    expect_store(32'h128, arm_isa_pkg::XFER_WORD, 32'h0000_8E7F);
    expect_store(32'h12C, arm_isa_pkg::XFER_WORD, 32'hFFFF_8E7F);
    expect_store(32'h130, arm_isa_pkg::XFER_WORD, 32'h0000_7FC3);
    expect_store(32'h134, arm_isa_pkg::XFER_WORD, 32'hFFFF_FF8E);
    expect_store(32'h138, arm_isa_pkg::XFER_WORD, 32'h7812_3456);

    // Branch over two poison stores, target at 0x9C
    add_instr(imm_instr(arm_isa_pkg::OP_MOV, 10, 0, int'(POISON)));
    add_instr(imm_instr(arm_isa_pkg::OP_MOV, 15, 0, 'h09C));
    add_instr(xfer_instr(arm_isa_pkg::OP_STR, 10, 14, arm_isa_pkg::XFER_WORD, 1'b0, 'h3C));
    add_instr(xfer_instr(arm_isa_pkg::OP_STR, 10, 14, arm_isa_pkg::XFER_WORD, 1'b0, 'h40));
    add_instr(xfer_instr(arm_isa_pkg::OP_STR, 15, 14, arm_isa_pkg::XFER_WORD, 1'b0, 'h3C));
    expect_store(32'h13C, arm_isa_pkg::XFER_WORD, 32'h0000_00A0);  // Target address + 4
    add_instr({arm_isa_pkg::OP_HALT, 28'd0});
  endtask

  // ==================================================
  // Memory models
  // ==================================================
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [8:0] base;
    base = {addr[8:2], 2'b00};
    return {dmem[base + 9'd3], dmem[base + 9'd2], dmem[base + 9'd1], dmem[base]};
  endfunction

  task automatic write_lanes(input logic [31:0] addr, input arm_isa_pkg::xfer_size_t size,
                             input logic [31:0] data);
    logic [8:0] base;
    case (size)
      arm_isa_pkg::XFER_BYTE: dmem[addr[8:0]] = data[7:0];
      arm_isa_pkg::XFER_HALF: begin
        base = {addr[8:1], 1'b0};
        dmem[base]        = data[7:0];
        dmem[base + 9'd1] = data[15:8];
      end
      default: begin
        base = {addr[8:2], 2'b00};
        dmem[base]        = data[7:0];
        dmem[base + 9'd1] = data[15:8];
        dmem[base + 9'd2] = data[23:16];
        dmem[base + 9'd3] = data[31:24];
      end
    endcase
  endtask

  task automatic load_memories();
    int i;
    for (i = 0; i < IMEM_WORDS; i++) begin
      if (i < prog_q.size()) begin
        imem[i] = prog_q[i];
      end else begin
        imem[i] = {arm_isa_pkg::OP_HALT, 28'(i * 4)};  // Halt tagged with its address
      end
    end
    for (i = 0; i < DMEM_BYTES; i++) begin
      dmem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3C;
    end
    write_lanes(32'h80, arm_isa_pkg::XFER_WORD, 32'h8E7F_C3A1);
    write_lanes(32'h84, arm_isa_pkg::XFER_WORD, 32'h1234_5678);
  endtask

  always @(posedge clk) begin
    if (imem_req) begin
      imem_rdata <= imem[imem_addr[7:2]];  // One cycle read latency
    end
  end

  // Ready drawn at random while a request waits
  always @(posedge clk) begin
    if (reset) begin
      dmem_ready <= 1'b0;
    end else if (dmem_valid && dmem_ready) begin
      if (dmem_write) begin
        seen.addr = dmem_addr;
        seen.size = dmem_size;
        seen.data = dmem_wdata;
        got_q.push_back(seen);
        write_lanes(dmem_addr, dmem_size, dmem_wdata);
        if (dmem_wdata == POISON) begin
          $display("ERROR: a skipped store reached memory at address %h", dmem_addr);
          error_count++;
        end
      end
      dmem_ready <= 1'b0;
    end else if (dmem_valid) begin
      dmem_ready <= ($random(seed) & 3) != 0;
      dmem_rdata <= read_word(dmem_addr);
    end
    if (halt_seen && dmem_valid) begin
      $display("ERROR: data request issued after the core halted");
      error_count++;
    end
    if (halted) halt_seen = 1'b1;
  end

  task automatic compare_store(input int idx);
    store_t got;
    store_t exp;
    got = got_q[idx];
    exp = exp_q[idx];
    if (got.addr != exp.addr) begin
      $display("MISMATCH store %0d dmem_addr: got %h expected %h", idx, got.addr, exp.addr);
      mismatch_count++;
    end
    if (got.size != exp.size) begin
      $display("MISMATCH store %0d dmem_size: got %h expected %h", idx, got.size, exp.size);
      mismatch_count++;
    end
    if (got.data != exp.data) begin
      $display("MISMATCH store %0d dmem_wdata: got %h expected %h", idx, got.data, exp.data);
      mismatch_count++;
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    int i;
    int cycles;
    seed           = 32'h7193_deda;
    mismatch_count = 0;
    error_count    = 0;
    halt_seen      = 1'b0;
    reset          = 1'b1;
    imem_rdata     = '0;
    dmem_ready     = 1'b0;
    dmem_rdata     = '0;
    build_program();
    load_memories();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    for (i = 0; i < exp_q.size(); i++) begin
      cycles = 0;
      while (got_q.size() <= i && cycles < STORE_TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (got_q.size() <= i) begin
        $display("ERROR: store %0d did not arrive within %0d cycles", i, STORE_TIMEOUT);
        error_count++;
        break;
      end
      compare_store(i);
    end

    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("ERROR: halted did not rise within %0d cycles", HALT_TIMEOUT);
      error_count++;
    end
    repeat (QUIET_CYCLES) @(negedge clk);
    if (got_q.size() != exp_q.size()) begin
      $display("ERROR: %0d stores seen where %0d were expected", got_q.size(), exp_q.size());
      error_count++;
    end

    $display("Checks done with %0d mismatches and %0d other errors", mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
